/* cpu_pkg.sv */
package cpu_pkg;

	typedef enum logic [5:0] {
		op_base = 6'b100000,
		op_addi = 6'b101000,
		op_ori  = 6'b101100,
		op_xori = 6'b101011,
		op_movi = 6'b100010,
		op_lwi  = 6'b000010,
		op_swi  = 6'b001010,
		op_ls   = 6'b011100
	} opcode_e;

	typedef enum logic [4:0] {
		base_add   = 5'd0,
		base_sub   = 5'd1,
		base_and   = 5'd2,
		base_xor   = 5'd3,
		base_or    = 5'd4,
		base_slli  = 5'd8,
		base_srli  = 5'd9,
		base_rotri = 5'd11
	} base_op_e;

	typedef enum logic [7:0] {
		ls_lw = 8'h02,
		ls_sw = 8'h0a
	} ls_op_e;

	typedef enum logic [2:0] {
		ph_fetch,
		ph_decode,
		ph_execute,
		ph_mem_access,
		ph_writeback
	} phase_e;

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_srl,
		alu_sll,
		alu_ror,
		alu_pass_b
	} alu_op_e;

	// operand b source
	typedef enum logic [1:0] {
		opnd_rb,
		opnd_imm,
		opnd_imm_x4,
		opnd_rb_shifted
	} opnd_sel_e;

	typedef enum logic [1:0] {
		ext_zero5,
		ext_sign15,
		ext_zero15,
		ext_sign20
	} ext_sel_e;

	typedef enum logic {
		wr_alu,
		wr_load
	} write_sel_e;

	typedef struct packed {
		alu_op_e    alu_op;
		opnd_sel_e  operand_sel;
		ext_sel_e   ext_sel;
		logic       mem_read;
		logic       mem_write;
		logic       reg_write;
		write_sel_e write_sel;
		logic [4:0] rt;
		logic [4:0] ra;
		logic [4:0] rb;
		logic [19:0] imm20;
		logic [1:0] sv;
	} ctrl_t;

	typedef struct packed {
		logic [31:0] pc;
		logic        reg_write;
		logic [4:0]  rt;
		logic [31:0] write_data;
	} retire_t;

	typedef struct packed {
		logic        awvalid;
		logic [31:0] awaddr;
		logic        wvalid;
		logic [31:0] wdata;
		logic [3:0]  wstrb;
		logic        bready;
		logic        arvalid;
		logic [31:0] araddr;
		logic        rready;
	} axil_req_t;

	typedef struct packed {
		logic        awready;
		logic        wready;
		logic        bvalid;
		logic [1:0]  bresp;
		logic        arready;
		logic        rvalid;
		logic [31:0] rdata;
		logic [1:0]  rresp;
	} axil_rsp_t;

endpackage

/* fetch_unit.sv */
`timescale 1ns/1ns

module fetch_unit import cpu_pkg::*; #(
	parameter logic [31:0] RESET_PC = 32'h0
) (
	input  logic        clock,
	input  logic        reset,
	input  phase_e      phase,
	input  logic [31:0] imem_data,
	output logic [31:0] pc,
	output logic [31:0] ir
);

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			pc <= RESET_PC;
		end else if (phase == ph_writeback) begin
			pc <= pc + 32'd4;
		end
	end

	// instruction port answers in the same cycle
	always_ff @(posedge clock) begin
		if (phase == ph_fetch) begin
			ir <= imem_data;
		end
	end

endmodule

/* controller.sv */
`timescale 1ns/1ns

module controller import cpu_pkg::*; (
	input  logic        clock,
	input  logic        reset,
	input  logic [31:0] ir,
	input  logic        mem_done,
	output phase_e      phase,
	output ctrl_t       ctrl,
	output logic        mem_start
);

	opcode_e  opcode;
	base_op_e base_op;
	ls_op_e   ls_op;
	logic     mem_op;

	assign opcode  = opcode_e'(ir[30:25]);
	assign base_op = base_op_e'(ir[4:0]);
	assign ls_op   = ls_op_e'(ir[7:0]);
	assign mem_op  = ctrl.mem_read | ctrl.mem_write;

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			phase <= ph_fetch;
		end else begin
			case (phase)
				ph_fetch:   phase <= ph_decode;
				ph_decode:  phase <= ph_execute;
				ph_execute: phase <= ph_mem_access;
				ph_mem_access: begin
					// stay here until the bus transfer completes
					if (!mem_op || mem_done) begin
						phase <= ph_writeback;
					end
				end
				default:    phase <= ph_fetch;
			endcase
		end
	end

	// high in the first mem_access cycle only
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			mem_start <= 1'b0;
		end else begin
			mem_start <= (phase == ph_execute) && mem_op;
		end
	end

	always_comb begin
		ctrl = '0;
		ctrl.rt = ir[24:20];
		ctrl.ra = ir[19:15];
		ctrl.rb = ir[14:10];
		ctrl.imm20 = ir[19:0];
		ctrl.sv = ir[9:8];
		case (opcode)
			op_base: begin
				ctrl.reg_write = 1'b1;
				case (base_op)
					base_add: ctrl.alu_op = alu_add;
					base_sub: ctrl.alu_op = alu_sub;
					base_and: ctrl.alu_op = alu_and;
					base_xor: ctrl.alu_op = alu_xor;
					base_or:  ctrl.alu_op = alu_or;
					base_slli: begin
						ctrl.alu_op = alu_sll;
						ctrl.operand_sel = opnd_imm;
					end
					base_srli: begin
						ctrl.alu_op = alu_srl;
						ctrl.operand_sel = opnd_imm;
					end
					base_rotri: begin
						ctrl.alu_op = alu_ror;
						ctrl.operand_sel = opnd_imm;
					end
					default:  ctrl.reg_write = 1'b0;
				endcase
			end
			op_addi: begin
				ctrl.reg_write = 1'b1;
				ctrl.operand_sel = opnd_imm;
				ctrl.ext_sel = ext_sign15;
			end
			op_ori: begin
				ctrl.reg_write = 1'b1;
				ctrl.alu_op = alu_or;
				ctrl.operand_sel = opnd_imm;
				ctrl.ext_sel = ext_zero15;
			end
			op_xori: begin
				ctrl.reg_write = 1'b1;
				ctrl.alu_op = alu_xor;
				ctrl.operand_sel = opnd_imm;
				ctrl.ext_sel = ext_zero15;
			end
			op_movi: begin
				ctrl.reg_write = 1'b1;
				ctrl.alu_op = alu_pass_b;
				ctrl.operand_sel = opnd_imm;
				ctrl.ext_sel = ext_sign20;
			end
			op_lwi: begin
				ctrl.reg_write = 1'b1;
				ctrl.mem_read = 1'b1;
				ctrl.write_sel = wr_load;
				ctrl.operand_sel = opnd_imm_x4;
				ctrl.ext_sel = ext_sign15;
			end
			op_swi: begin
				ctrl.mem_write = 1'b1;
				ctrl.operand_sel = opnd_imm_x4;
				ctrl.ext_sel = ext_sign15;
			end
			op_ls: begin
				ctrl.operand_sel = opnd_rb_shifted;
				case (ls_op)
					ls_lw: begin
						ctrl.reg_write = 1'b1;
						ctrl.mem_read = 1'b1;
						ctrl.write_sel = wr_load;
					end
					ls_sw:   ctrl.mem_write = 1'b1;
					default: ctrl.operand_sel = opnd_rb;
				endcase
			end
			default: ;
		endcase
	end

	mem_done_in_mem_access: assert property (@(posedge clock) disable iff (reset)
		mem_done |-> phase == ph_mem_access);

endmodule

/* register_file.sv */
`timescale 1ns/1ns

module register_file (
	input  logic        clock,
	input  logic        reset,
	input  logic [4:0]  ra,
	input  logic [4:0]  rb,
	input  logic [4:0]  rt,
	input  logic        write_enable,
	input  logic [31:0] write_data,
	output logic [31:0] ra_data,
	output logic [31:0] rb_data
);

	logic [31:0] regs [32];

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			regs <= '{default: '0};
		end else if (write_enable) begin
			// r0 is an ordinary register here
			regs[rt] <= write_data;
		end
	end

	assign ra_data = regs[ra];
	assign rb_data = regs[rb];

endmodule

/* execute_unit.sv */
`timescale 1ns/1ns

module execute_unit import cpu_pkg::*; (
	input  logic        clock,
	input  logic        reset,
	input  phase_e      phase,
	input  ctrl_t       ctrl,
	input  logic [31:0] ra_data,
	input  logic [31:0] rb_data,
	output logic [31:0] result
);

	logic [31:0] ext_imm;
	logic [31:0] operand_b;
	logic [31:0] alu_out;
	logic [4:0]  amount;
	logic [63:0] rotated;

	always_comb begin
		case (ctrl.ext_sel)
			ext_zero5:  ext_imm = {27'b0, ctrl.imm20[14:10]};
			ext_sign15: ext_imm = {{17{ctrl.imm20[14]}}, ctrl.imm20[14:0]};
			ext_zero15: ext_imm = {17'b0, ctrl.imm20[14:0]};
			default:    ext_imm = {{12{ctrl.imm20[19]}}, ctrl.imm20};
		endcase
	end

	// memory offsets are scaled to words
	always_comb begin
		case (ctrl.operand_sel)
			opnd_rb:     operand_b = rb_data;
			opnd_imm:    operand_b = ext_imm;
			opnd_imm_x4: operand_b = ext_imm << 2;
			default:     operand_b = rb_data << ctrl.sv;
		endcase
	end

	assign amount  = operand_b[4:0];
	assign rotated = {ra_data, ra_data} >> amount;

	always_comb begin
		case (ctrl.alu_op)
			alu_add:    alu_out = ra_data + operand_b;
			alu_sub:    alu_out = ra_data - operand_b;
			alu_and:    alu_out = ra_data & operand_b;
			alu_or:     alu_out = ra_data | operand_b;
			alu_xor:    alu_out = ra_data ^ operand_b;
			alu_srl:    alu_out = ra_data >> amount;
			alu_sll:    alu_out = ra_data << amount;
			alu_ror:    alu_out = rotated[31:0];
			alu_pass_b: alu_out = operand_b;
			default:    alu_out = '0;
		endcase
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			result <= '0;
		end else if (phase == ph_execute) begin
			result <= alu_out;
		end
	end

endmodule

/* axil_data_port.sv */
`timescale 1ns/1ns

module axil_data_port import cpu_pkg::*; (
	input  logic        clock,
	input  logic        reset,
	input  logic        start,
	input  ctrl_t       ctrl,
	input  logic [31:0] address,
	input  logic [31:0] store_data,
	output axil_req_t   axil_req,
	input  axil_rsp_t   axil_rsp,
	output logic        done,
	output logic [31:0] load_data
);

	typedef enum logic [1:0] {
		st_idle,
		st_write,
		st_write_response,
		st_read
	} port_state_e;

	port_state_e state;
	logic        awvalid, wvalid, arvalid;
	logic        aw_done, w_done;
	logic [31:0] addr_q, wdata_q;

	// address and data channels may finish in either order
	assign aw_done = !awvalid || axil_rsp.awready;
	assign w_done  = !wvalid || axil_rsp.wready;

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			state <= st_idle;
			awvalid <= 1'b0;
			wvalid <= 1'b0;
			arvalid <= 1'b0;
		end else begin
			case (state)
				st_idle: begin
					if (start && ctrl.mem_write) begin
						awvalid <= 1'b1;
						wvalid <= 1'b1;
						state <= st_write;
					end else if (start && ctrl.mem_read) begin
						arvalid <= 1'b1;
						state <= st_read;
					end
				end
				st_write: begin
					if (axil_rsp.awready) awvalid <= 1'b0;
					if (axil_rsp.wready) wvalid <= 1'b0;
					if (aw_done && w_done) state <= st_write_response;
				end
				st_write_response: begin
					if (axil_rsp.bvalid) state <= st_idle;
				end
				default: begin
					if (axil_rsp.arready) arvalid <= 1'b0;
					if (axil_rsp.rvalid) state <= st_idle;
				end
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (state == st_idle && start) begin
			addr_q <= address;
			wdata_q <= store_data;
		end
		if (state == st_read && axil_rsp.rvalid) begin
			load_data <= axil_rsp.rdata;
		end
	end

	assign done = (state == st_write_response && axil_rsp.bvalid) ||
		(state == st_read && axil_rsp.rvalid);

	always_comb begin
		axil_req.awvalid = awvalid;
		axil_req.awaddr = addr_q;
		axil_req.wvalid = wvalid;
		axil_req.wdata = wdata_q;
		axil_req.wstrb = 4'hf;
		axil_req.bready = (state == st_write_response);
		axil_req.arvalid = arvalid;
		axil_req.araddr = addr_q;
		axil_req.rready = (state == st_read);
	end

	aw_held: assert property (@(posedge clock) disable iff (reset)
		awvalid && !axil_rsp.awready |=> awvalid && $stable(axil_req.awaddr));
	w_held: assert property (@(posedge clock) disable iff (reset)
		wvalid && !axil_rsp.wready |=> wvalid && $stable(axil_req.wdata));
	ar_held: assert property (@(posedge clock) disable iff (reset)
		arvalid && !axil_rsp.arready |=> arvalid && $stable(axil_req.araddr));

endmodule

/* cpu_top.sv */
`timescale 1ns/1ns

module cpu_top import cpu_pkg::*; #(
	parameter logic [31:0] RESET_PC = 32'h0
) (
	input  logic        clock,
	input  logic        reset,
	output logic [31:0] imem_addr,
	input  logic [31:0] imem_data,
	output axil_req_t   axil_req,
	input  axil_rsp_t   axil_rsp,
	output logic        retire_valid,
	output retire_t     retire
);

	phase_e      phase;
	ctrl_t       ctrl;
	logic [31:0] pc, ir;
	logic [31:0] ra_data, rb_data;
	logic [31:0] result, load_data, write_data;
	logic [4:0]  rb_addr;
	logic        mem_start, mem_done, write_enable;

	fetch_unit #(.RESET_PC(RESET_PC)) i_fetch (
		.clock(clock), .reset(reset), .phase(phase),
		.imem_data(imem_data), .pc(pc), .ir(ir)
	);

	controller i_controller (
		.clock(clock), .reset(reset), .ir(ir), .mem_done(mem_done),
		.phase(phase), .ctrl(ctrl), .mem_start(mem_start)
	);

	// port b reads rt as store data once the address is registered
	assign rb_addr = (phase == ph_mem_access) ? ctrl.rt : ctrl.rb;
	assign write_enable = ctrl.reg_write && (phase == ph_writeback);
	assign write_data = (ctrl.write_sel == wr_load) ? load_data : result;

	register_file i_regs (
		.clock(clock), .reset(reset), .ra(ctrl.ra), .rb(rb_addr), .rt(ctrl.rt),
		.write_enable(write_enable), .write_data(write_data),
		.ra_data(ra_data), .rb_data(rb_data)
	);

	execute_unit i_execute (
		.clock(clock), .reset(reset), .phase(phase), .ctrl(ctrl),
		.ra_data(ra_data), .rb_data(rb_data), .result(result)
	);

	axil_data_port i_data_port (
		.clock(clock), .reset(reset), .start(mem_start), .ctrl(ctrl),
		.address(result), .store_data(rb_data), .axil_req(axil_req),
		.axil_rsp(axil_rsp), .done(mem_done), .load_data(load_data)
	);

	assign imem_addr = pc;
	assign retire_valid = (phase == ph_writeback);

	always_comb begin
		retire.pc = pc;
		retire.reg_write = ctrl.reg_write;
		retire.rt = ctrl.rt;
		retire.write_data = write_data;
	end

endmodule

/* tb_cpu.sv */
`timescale 1ns/1ns

module tb_cpu import cpu_pkg::*; ();

	localparam logic [31:0] RESET_PC = 32'h0000_0040;
	localparam int NUM_INSTR = 256;
	localparam int TIMEOUT_CYCLES = 8 + NUM_INSTR * 5 + NUM_INSTR * 8 + 200;

	logic        clock = 1'b0;
	logic        reset;
	logic [31:0] imem_addr;
	logic [31:0] imem_data;
	axil_req_t   axil_req;
	axil_rsp_t   axil_rsp;
	logic        retire_valid;
	retire_t     retire;

	logic [31:0] rng = 32'h8305_b5e1;
	logic [31:0] prog [256];
	logic [31:0] bus_mem [64];
	logic [31:0] model_mem [64];
	logic [31:0] model_regs [32];
	logic [31:0] model_pc;

	// expectation for the instruction in flight
	retire_t     exp_retire;
	int          exp_class, exp_reads, exp_writes;
	logic [31:0] exp_addr, exp_data;

	int   reads_seen, writes_seen, retired, cycles, last_retire;
	logic first_seen, timed_out;
	int   checks [6];
	int   fails [6];

	// slave side of the bus
	logic        hs_aw, hs_w, hs_b, hs_ar, hs_r;
	logic        aw_got, w_got, b_pending, r_pending;
	logic [31:0] aw_addr_q, w_data_q, ar_addr_q;
	logic [3:0]  w_strb_q;
	int          aw_left, w_left, ar_left, b_left, r_left;

	cpu_top #(.RESET_PC(RESET_PC)) i_dut (
		.clock(clock), .reset(reset), .imem_addr(imem_addr), .imem_data(imem_data),
		.axil_req(axil_req), .axil_rsp(axil_rsp),
		.retire_valid(retire_valid), .retire(retire)
	);

	assign imem_data = prog[imem_addr[9:2]];

	always #10 clock = ~clock;

	always @(posedge clock) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) timed_out = 1'b1;
	end

	function automatic logic [31:0] next_random();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	function automatic logic [31:0] random_instr();
		logic [31:0] w;
		logic [31:0] sel;
		int          kind;
		w = next_random();
		sel = next_random();
		kind = int'(sel[15:0] % 30);
		// keep rt and ra within r0..r7
		w[24:23] = 2'b00;
		w[19:18] = 2'b00;
		if (kind == 0) begin
			w[30:25] = {2'b11, w[28:25]};
		end else if (kind == 1) begin
			w[30:25] = op_base;
			w[4] = 1'b1;
		end else if (kind == 2) begin
			w[30:25] = op_ls;
			w[7:4] = 4'h1;
		end else if (kind < 13) begin
			w[30:25] = op_base;
			w[14:13] = 2'b00;
			case (sel[18:16])
				3'd0: w[4:0] = base_add;
				3'd1: w[4:0] = base_sub;
				3'd2: w[4:0] = base_and;
				3'd3: w[4:0] = base_xor;
				3'd4: w[4:0] = base_or;
				3'd5: w[4:0] = base_slli;
				3'd6: w[4:0] = base_srli;
				default: w[4:0] = base_rotri;
			endcase
		end else if (kind < 19) begin
			case (sel[17:16])
				2'd0: w[30:25] = op_addi;
				2'd1: w[30:25] = op_ori;
				2'd2: w[30:25] = op_xori;
				default: begin
					w[30:25] = op_movi;
					w[19:18] = sel[21:20];
				end
			endcase
		end else begin
			case (sel[17:16])
				2'd0: w[30:25] = op_lwi;
				2'd1: w[30:25] = op_swi;
				default: begin
					w[30:25] = op_ls;
					w[14:13] = 2'b00;
					w[7:0] = sel[16] ? ls_sw : ls_lw;
				end
			endcase
		end
		return w;
	endfunction

	function automatic logic [31:0] rotate_right(logic [31:0] value, logic [4:0] amount);
		return (value >> amount) | (value << (6'd32 - {1'b0, amount}));
	endfunction

	function automatic string class_name(int c);
		case (c)
			0: return "reset";
			1: return "register alu and shift";
			2: return "immediate";
			3: return "store";
			4: return "load";
			default: return "invalid op";
		endcase
	endfunction

	// reference model, runs one instruction ahead of its retire
	task automatic predict_next();
		logic [31:0] w, a, b, res, addr, sext15;
		logic        do_load, do_store;
		w = prog[model_pc[9:2]];
		a = model_regs[w[19:15]];
		b = model_regs[w[14:10]];
		sext15 = {{17{w[14]}}, w[14:0]};
		res = '0;
		addr = '0;
		do_load = 1'b0;
		do_store = 1'b0;
		exp_retire = '0;
		exp_retire.pc = model_pc;
		exp_retire.rt = w[24:20];
		exp_retire.reg_write = 1'b1;
		exp_class = 2;
		exp_reads = 0;
		exp_writes = 0;
		case (opcode_e'(w[30:25]))
			op_base: begin
				exp_class = 1;
				case (base_op_e'(w[4:0]))
					base_add:   res = a + b;
					base_sub:   res = a - b;
					base_and:   res = a & b;
					base_xor:   res = a ^ b;
					base_or:    res = a | b;
					base_slli:  res = a << w[14:10];
					base_srli:  res = a >> w[14:10];
					base_rotri: res = rotate_right(a, w[14:10]);
					default:    exp_class = 5;
				endcase
			end
			op_addi: res = a + sext15;
			op_ori:  res = a | {17'b0, w[14:0]};
			op_xori: res = a ^ {17'b0, w[14:0]};
			op_movi: res = {{12{w[19]}}, w[19:0]};
			op_lwi: begin
				addr = a + (sext15 << 2);
				do_load = 1'b1;
			end
			op_swi: begin
				addr = a + (sext15 << 2);
				do_store = 1'b1;
			end
			op_ls: begin
				addr = a + (b << w[9:8]);
				case (ls_op_e'(w[7:0]))
					ls_lw:   do_load = 1'b1;
					ls_sw:   do_store = 1'b1;
					default: exp_class = 5;
				endcase
			end
			default: exp_class = 5;
		endcase
		if (do_load) begin
			exp_class = 4;
			exp_reads = 1;
			exp_addr = addr;
			res = model_mem[addr[7:2]];
		end
		if (do_store) begin
			exp_class = 3;
			exp_writes = 1;
			exp_addr = addr;
			exp_data = model_regs[w[24:20]];
			model_mem[addr[7:2]] = exp_data;
		end
		if (exp_class == 3 || exp_class == 5) begin
			exp_retire.reg_write = 1'b0;
		end else begin
			exp_retire.write_data = res;
			model_regs[w[24:20]] = res;
		end
		model_pc = model_pc + 32'd4;
	endtask

	task automatic note_check(int cls, logic ok);
		checks[cls]++;
		if (!ok) fails[cls]++;
	endtask

	task automatic check_quiet(axil_req_t req, logic valid);
		logic [4:0] flags;
		flags = {req.awvalid, req.wvalid, req.arvalid, req.bready, req.rready};
		if (flags !== 5'h0) $display("FAILED axil_req valid/ready bits %h expected 00", flags);
		if (valid !== 1'b0) $display("FAILED retire_valid %h expected 0", valid);
		note_check(0, flags === 5'h0 && valid === 1'b0);
	endtask

	task automatic check_retire(retire_t got, retire_t exp);
		logic ok;
		ok = got.pc === exp.pc && got.reg_write === exp.reg_write && got.rt === exp.rt &&
			(!exp.reg_write || got.write_data === exp.write_data);
		if (!ok)
			$display("FAILED retire pc %h reg_write %h rt %h write_data %h, expected %h %h %h %h",
				got.pc, got.reg_write, got.rt, got.write_data,
				exp.pc, exp.reg_write, exp.rt, exp.write_data);
		note_check(exp_class, ok);
	endtask

	task automatic check_write(logic [31:0] addr, logic [31:0] data, logic [3:0] strb);
		logic ok;
		if (exp_writes == 0) begin
			$display("unexpected write to address %h during pc %h", addr, exp_retire.pc);
			ok = 1'b0;
		end else begin
			if (addr !== exp_addr) $display("FAILED awaddr %h expected %h", addr, exp_addr);
			if (data !== exp_data) $display("FAILED wdata %h expected %h", data, exp_data);
			if (strb !== 4'hf) $display("FAILED wstrb %h expected f", strb);
			ok = addr === exp_addr && data === exp_data && strb === 4'hf;
		end
		note_check(exp_class, ok);
	endtask

	task automatic check_read_address(logic [31:0] addr);
		logic ok;
		if (exp_reads == 0) begin
			$display("unexpected read from address %h during pc %h", addr, exp_retire.pc);
			ok = 1'b0;
		end else begin
			ok = addr === exp_addr;
			if (!ok) $display("FAILED araddr %h expected %h", addr, exp_addr);
		end
		note_check(exp_class, ok);
	endtask

	// handshakes that complete at the coming rising edge
	task automatic watch_bus();
		hs_aw = axil_req.awvalid && axil_rsp.awready;
		hs_w = axil_req.wvalid && axil_rsp.wready;
		hs_b = axil_req.bready && axil_rsp.bvalid;
		hs_ar = axil_req.arvalid && axil_rsp.arready;
		hs_r = axil_req.rready && axil_rsp.rvalid;
		if (hs_aw) begin
			aw_got = 1'b1;
			aw_addr_q = axil_req.awaddr;
		end
		if (hs_w) begin
			w_got = 1'b1;
			w_data_q = axil_req.wdata;
			w_strb_q = axil_req.wstrb;
		end
		if (aw_got && w_got) begin
			check_write(aw_addr_q, w_data_q, w_strb_q);
			bus_mem[aw_addr_q[7:2]] = w_data_q;
			writes_seen++;
			aw_got = 1'b0;
			w_got = 1'b0;
			b_pending = 1'b1;
		end
		if (hs_ar) begin
			check_read_address(axil_req.araddr);
			ar_addr_q = axil_req.araddr;
			reads_seen++;
			r_pending = 1'b1;
		end
	endtask

	task automatic watch_retire();
		logic ok;
		if (!first_seen && (reset || !retire_valid)) check_quiet(axil_req, retire_valid);
		if (retire_valid && !reset) begin
			first_seen = 1'b1;
			check_retire(retire, exp_retire);
			ok = reads_seen == exp_reads && writes_seen == exp_writes;
			if (!ok)
				$display("pc %h made %0d reads and %0d writes, expected %0d and %0d",
					exp_retire.pc, reads_seen, writes_seen, exp_reads, exp_writes);
			note_check(exp_class, ok);
			if (exp_reads + exp_writes == 0 && last_retire >= 0) begin
				ok = cycles - last_retire == 5;
				if (!ok)
					$display("pc %h took %0d cycles instead of 5",
						exp_retire.pc, cycles - last_retire);
				note_check(exp_class, ok);
			end
			last_retire = cycles;
			retired++;
			reads_seen = 0;
			writes_seen = 0;
			predict_next();
		end
	endtask

	task automatic step_delay(inout int left, output logic fire);
		if (left < 0) left = int'(next_random() % 4);
		fire = (left == 0);
		if (left == 0) left = -1;
		else left--;
	endtask

	// ready and response lines, 0 to 3 cycles late
	task automatic respond();
		logic fire;
		if (hs_aw) axil_rsp.awready = 1'b0;
		if (hs_w) axil_rsp.wready = 1'b0;
		if (hs_b) axil_rsp.bvalid = 1'b0;
		if (hs_ar) axil_rsp.arready = 1'b0;
		if (hs_r) axil_rsp.rvalid = 1'b0;
		if (axil_req.awvalid && !axil_rsp.awready) begin
			step_delay(aw_left, fire);
			if (fire) axil_rsp.awready = 1'b1;
		end
		if (axil_req.wvalid && !axil_rsp.wready) begin
			step_delay(w_left, fire);
			if (fire) axil_rsp.wready = 1'b1;
		end
		if (axil_req.arvalid && !axil_rsp.arready) begin
			step_delay(ar_left, fire);
			if (fire) axil_rsp.arready = 1'b1;
		end
		if (b_pending) begin
			step_delay(b_left, fire);
			if (fire) begin
				axil_rsp.bvalid = 1'b1;
				axil_rsp.bresp = 2'(next_random());
				b_pending = 1'b0;
			end
		end
		if (r_pending) begin
			step_delay(r_left, fire);
			if (fire) begin
				axil_rsp.rvalid = 1'b1;
				axil_rsp.rdata = bus_mem[ar_addr_q[7:2]];
				axil_rsp.rresp = 2'(next_random());
				r_pending = 1'b0;
			end
		end
	endtask

	initial begin
		forever begin
			@(negedge clock);
			watch_bus();
			watch_retire();
			@(posedge clock);
			#2;
			respond();
		end
	end

	initial begin
		logic [7:0]  slot;
		logic [31:0] w;
		int          total, errors;
		reset = 1'b1;
		axil_rsp = '0;
		cycles = 0;
		timed_out = 1'b0;
		retired = 0;
		first_seen = 1'b0;
		last_retire = -1;
		reads_seen = 0;
		writes_seen = 0;
		{hs_aw, hs_w, hs_b, hs_ar, hs_r} = '0;
		{aw_got, w_got, b_pending, r_pending} = '0;
		{aw_left, w_left, ar_left, b_left, r_left} = {-32'sd1, -32'sd1, -32'sd1, -32'sd1, -32'sd1};
		for (int c = 0; c < 6; c++) begin
			checks[c] = 0;
			fails[c] = 0;
		end
		for (int i = 0; i < 64; i++) begin
			model_mem[i] = next_random();
			bus_mem[i] = model_mem[i];
		end
		for (int i = 0; i < 256; i++) prog[i] = random_instr();
		// r1..r4 get random bases first
		for (int k = 1; k <= 4; k++) begin
			slot = RESET_PC[9:2] + 8'(k - 1);
			w = next_random();
			prog[slot] = {1'b0, op_movi, 5'(k), w[19:0]};
		end
		for (int r = 0; r < 32; r++) model_regs[r] = '0;
		model_pc = RESET_PC;
		predict_next();
		repeat (8) @(posedge clock);
		#2;
		reset = 1'b0;
		wait (retired == NUM_INSTR || timed_out);
		total = 0;
		errors = 0;
		if (timed_out)
			$display("timeout after %0d cycles, %0d of %0d instructions retired",
				cycles, retired, NUM_INSTR);
		if (timed_out) errors++;
		for (int c = 0; c < 6; c++) begin
			$display("%s: %0d checks, %0d errors", class_name(c), checks[c], fails[c]);
			total += checks[c];
			errors += fails[c];
		end
		$display("%0d checks in total, %0d errors", total, errors);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

/* sim.f */
cpu_pkg.sv
fetch_unit.sv
controller.sv
register_file.sv
execute_unit.sv
axil_data_port.sv
cpu_top.sv
tb_cpu.sv

/* run_sim.sh */
#!/bin/sh
# build with Verilator, run, then judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_cpu -f sim.f \
	&& ./obj_dir/Vtb_cpu > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "TEST RESULT: PASS" sim.log && ! grep -q "TEST RESULT: FAIL" sim.log \
	|| { echo "simulation failed"; exit 1; }
exit 0
